//--- files.f
+incdir+verilog
verilog/dmc_cfg_pkg.sv
verilog/tag_master.sv
verilog/tag_client.sv
verilog/dmc_cfg_decoder.sv
verilog/dmc_cfg_top.sv
bench/dmc_cfg_tb.sv

//--- Bender.yml
package:
  name: dmc_cfg

export_include_dirs:
  - verilog

sources:
  - verilog/dmc_cfg_pkg.sv
  - verilog/tag_master.sv
  - verilog/tag_client.sv
  - verilog/dmc_cfg_decoder.sv
  - verilog/dmc_cfg_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - bench/dmc_cfg_tb.sv

//--- bench/dmc_cfg_tb.sv
`include "dmc_cfg_macros.svh"

module dmc_cfg_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import dmc_cfg_pkg::*;

  localparam int num_entries_lp = 22;
  // packet and idle gap per entry plus reset margin
  localparam int timeout_lp     = num_entries_lp * 17 + 50;

  logic                  clk;
  logic                  rst_n;
  logic                  tag_data;
  logic                  tag_en;
  dmc_trefi_t            trefi;
  dmc_nibble_t           tmrd, trfc, trc, trp, tras, trrd, trcd, twr;
  dmc_nibble_t           twtr, trtp, tcas, col_width, row_width, init_cmd_cnt;
  logic [1:0]            bank_width;
  logic [1:0]            dqs_sel_cal;
  logic [5:0]            bank_pos;
  logic                  bypass;
  logic                  sys_reset;
  logic                  cfg_update;
  logic                  cfg_valid;

  // stimulus table as one array per column
  string                 tbl_name    [num_entries_lp];
  logic                  tbl_en      [num_entries_lp];
  logic [3:0]            tbl_id      [num_entries_lp];
  dmc_cfg_byte_t         tbl_payload [num_entries_lp];
  logic                  tbl_b2b     [num_entries_lp];
  logic                  tbl_accept  [num_entries_lp];

  // reference image and bookkeeping
  dmc_cfg_u                  model;
  logic [`DMC_CFG_BYTES-1:0] written;
  logic [31:0]               lcg_state;
  int                        exp_updates;
  int                        update_cnt;
  int                        cycle_cnt;

  dmc_cfg_top
    dut0
      (.clk_i         ( clk )
      ,.rst_n_i       ( rst_n )
      ,.tag_data_i    ( tag_data )
      ,.tag_en_i      ( tag_en )
      ,.trefi_o       ( trefi )
      ,.tmrd_o        ( tmrd )
      ,.trfc_o        ( trfc )
      ,.trc_o         ( trc )
      ,.trp_o         ( trp )
      ,.tras_o        ( tras )
      ,.trrd_o        ( trrd )
      ,.trcd_o        ( trcd )
      ,.twr_o         ( twr )
      ,.twtr_o        ( twtr )
      ,.trtp_o        ( trtp )
      ,.tcas_o        ( tcas )
      ,.col_width_o   ( col_width )
      ,.row_width_o   ( row_width )
      ,.init_cmd_cnt_o( init_cmd_cnt )
      ,.bank_width_o  ( bank_width )
      ,.dqs_sel_cal_o ( dqs_sel_cal )
      ,.bank_pos_o    ( bank_pos )
      ,.bypass_o      ( bypass )
      ,.sys_reset_o   ( sys_reset )
      ,.cfg_update_o  ( cfg_update )
      ,.cfg_valid_o   ( cfg_valid )
      );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // monitors

  always @(negedge clk)
  begin
    if (rst_n && cfg_update)
      update_cnt++;
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > timeout_lp)
    begin
      $display("timeout: the run did not finish within %0d cycles", timeout_lp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  //////////////////////////////////////////////////
  // compare tasks

  task automatic report_mismatch(input string test, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("** Error [%s] %s: expected %0h, actual %0h", test, field, exp, act);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_trefi(input string test, input string field,
                             input dmc_trefi_t exp, input dmc_trefi_t act);
    if (act !== exp)
      report_mismatch(test, field, 32'(exp), 32'(act));
  endtask

  task automatic check_nibble(input string test, input string field,
                              input dmc_nibble_t exp, input dmc_nibble_t act);
    if (act !== exp)
      report_mismatch(test, field, 32'(exp), 32'(act));
  endtask

  // 2 and 6 bit fields zero extended
  task automatic check_bits(input string test, input string field,
                            input logic [5:0] exp, input logic [5:0] act);
    if (act !== exp)
      report_mismatch(test, field, 32'(exp), 32'(act));
  endtask

  task automatic check_flag(input string test, input string field,
                            input logic exp, input logic act);
    if (act !== exp)
      report_mismatch(test, field, 32'(exp), 32'(act));
  endtask

  task automatic check_count(input string test, input int exp, input int act);
    if (act != exp)
      report_mismatch(test, "update count", exp, act);
  endtask

  task automatic check_outputs(input string test);
    check_trefi(test, "trefi", model.fields.trefi, trefi);
    check_nibble(test, "tmrd", model.fields.tmrd, tmrd);
    check_nibble(test, "trfc", model.fields.trfc, trfc);
    check_nibble(test, "trc", model.fields.trc, trc);
    check_nibble(test, "trp", model.fields.trp, trp);
    check_nibble(test, "tras", model.fields.tras, tras);
    check_nibble(test, "trrd", model.fields.trrd, trrd);
    check_nibble(test, "trcd", model.fields.trcd, trcd);
    check_nibble(test, "twr", model.fields.twr, twr);
    check_nibble(test, "twtr", model.fields.twtr, twtr);
    check_nibble(test, "trtp", model.fields.trtp, trtp);
    check_nibble(test, "tcas", model.fields.tcas, tcas);
    check_nibble(test, "col_width", model.fields.col_width, col_width);
    check_nibble(test, "row_width", model.fields.row_width, row_width);
    check_nibble(test, "init_cmd_cnt", model.fields.init_cmd_cnt, init_cmd_cnt);
    check_bits(test, "bank_width", 6'(model.fields.bank_width), 6'(bank_width));
    check_bits(test, "dqs_sel_cal", 6'(model.fields.dqs_sel_cal), 6'(dqs_sel_cal));
    check_bits(test, "bank_pos", model.fields.bank_pos, bank_pos);
    check_flag(test, "bypass", model.fields.bypass, bypass);
    check_flag(test, "sys_reset", model.fields.sys_reset, sys_reset);
    check_flag(test, "cfg_valid", &written, cfg_valid);
    // pulse must be over by now
    check_flag(test, "cfg_update", 1'b0, cfg_update);
    check_count(test, exp_updates, update_cnt);
  endtask

  //////////////////////////////////////////////////
  // stimulus

  task automatic set_entry(input int idx, input string name, input logic en,
                           input logic [3:0] id, input dmc_cfg_byte_t payload,
                           input logic b2b, input logic accept);
    tbl_name[idx]    = name;
    tbl_en[idx]      = en;
    tbl_id[idx]      = id;
    tbl_payload[idx] = payload;
    tbl_b2b[idx]     = b2b;
    tbl_accept[idx]  = accept;
  endtask

  task automatic build_table();
    dmc_cfg_byte_t r [num_entries_lp];
    for (int i = 0; i < num_entries_lp; i++)
    begin
      lcg_state = lcg_step(lcg_state);
      r[i]      = lcg_state[23:16];
    end
    for (int i = 0; i < `DMC_CFG_BYTES; i++)
      set_entry(i, $sformatf("write_byte_%0d", i), 1'b1, 4'(i), r[i], 1'b0, 1'b1);
    set_entry(12, "bypass_on", 1'b1, 4'd10, r[12] | 8'h40, 1'b0, 1'b1);
    set_entry(13, "bypass_off", 1'b1, 4'd10, r[13] & 8'hbf, 1'b0, 1'b1);
    set_entry(14, "sys_reset_on", 1'b1, 4'd11, r[14] | 8'h01, 1'b0, 1'b1);
    for (int i = 0; i < 4; i++)
      set_entry(15 + i, $sformatf("bad_id_%0d", 12 + i), 1'b1, 4'(12 + i), r[15 + i],
                1'b0, 1'b0);
    set_entry(19, "tag_disabled", 1'b0, 4'd4, r[19], 1'b0, 1'b0);
    set_entry(20, "b2b_first", 1'b1, 4'd5, r[20], 1'b1, 1'b1);
    set_entry(21, "b2b_second", 1'b1, 4'd8, r[21], 1'b0, 1'b1);
  endtask

  // start bit then id and payload MSB first at one bit per cycle
  task automatic send_packet(input logic en, input logic [3:0] id,
                             input dmc_cfg_byte_t payload);
    logic [`TAG_PACKET_BITS-1:0] pkt;
    pkt = {1'b1, id, payload};
    for (int b = `TAG_PACKET_BITS - 1; b >= 0; b--)
    begin
      @(posedge clk);
      #1;
      tag_en   = en;
      tag_data = pkt[b];
    end
  endtask

  task automatic wait_idle();
    @(posedge clk);
    #1;
    tag_en   = 1'b0;
    tag_data = 1'b0;
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic update_model(input logic en, input logic [3:0] id,
                              input dmc_cfg_byte_t payload);
    if (en && (id < `DMC_CFG_BYTES))
    begin
      model.bytes[id] = payload;
      written[id]     = 1'b1;
    end
  endtask

  initial
  begin
    rst_n       = 1'b0;
    tag_data    = 1'b0;
    tag_en      = 1'b0;
    model       = '0;
    written     = '0;
    lcg_state   = 32'h1068_1e75;
    exp_updates = 0;
    update_cnt  = 0;
    cycle_cnt   = 0;
    build_table();

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    check_outputs("after_reset");

    for (int i = 0; i < num_entries_lp; i++)
    begin
      send_packet(tbl_en[i], tbl_id[i], tbl_payload[i]);
      update_model(tbl_en[i], tbl_id[i], tbl_payload[i]);
      if (tbl_accept[i])
        exp_updates++;
      // second packet starts right after the last bit
      if (!tbl_b2b[i])
      begin
        wait_idle();
        check_outputs(tbl_name[i]);
      end
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- verilog/dmc_cfg_top.sv
`include "dmc_cfg_macros.svh"

module dmc_cfg_top
  (input  logic                     clk_i
  ,input  logic                     rst_n_i
  ,input  logic                     tag_data_i
  ,input  logic                     tag_en_i
  ,output dmc_cfg_pkg::dmc_trefi_t  trefi_o
  ,output dmc_cfg_pkg::dmc_nibble_t tmrd_o
  ,output dmc_cfg_pkg::dmc_nibble_t trfc_o
  ,output dmc_cfg_pkg::dmc_nibble_t trc_o
  ,output dmc_cfg_pkg::dmc_nibble_t trp_o
  ,output dmc_cfg_pkg::dmc_nibble_t tras_o
  ,output dmc_cfg_pkg::dmc_nibble_t trrd_o
  ,output dmc_cfg_pkg::dmc_nibble_t trcd_o
  ,output dmc_cfg_pkg::dmc_nibble_t twr_o
  ,output dmc_cfg_pkg::dmc_nibble_t twtr_o
  ,output dmc_cfg_pkg::dmc_nibble_t trtp_o
  ,output dmc_cfg_pkg::dmc_nibble_t tcas_o
  ,output dmc_cfg_pkg::dmc_nibble_t col_width_o
  ,output dmc_cfg_pkg::dmc_nibble_t row_width_o
  ,output dmc_cfg_pkg::dmc_nibble_t init_cmd_cnt_o
  ,output logic [1:0]               bank_width_o
  ,output logic [1:0]               dqs_sel_cal_o
  ,output logic [5:0]               bank_pos_o
  ,output logic                     bypass_o
  ,output logic                     sys_reset_o
  ,output logic                     cfg_update_o
  ,output logic                     cfg_valid_o
  );

  import dmc_cfg_pkg::*;

  logic [`DMC_CFG_BYTES-1:0]          client_strobe;
  dmc_cfg_byte_t                      tag_payload;
  dmc_cfg_byte_t [`DMC_CFG_BYTES-1:0] cfg_bytes;
  logic [`DMC_CFG_BYTES-1:0]          cfg_new;

  //////////////////////////////////////////////////
  // tag master

  tag_master
    btm
      (.clk_i          ( clk_i )
      ,.rst_n_i        ( rst_n_i )
      ,.tag_data_i     ( tag_data_i )
      ,.tag_en_i       ( tag_en_i )
      ,.client_strobe_o( client_strobe )
      ,.payload_o      ( tag_payload )
      );

  //////////////////////////////////////////////////
  // one client per configuration byte

  for (genvar i = 0; i < `DMC_CFG_BYTES; i++)
  begin : cfg_client
    tag_client
      btc
        (.clk_i    ( clk_i )
        ,.rst_n_i  ( rst_n_i )
        ,.strobe_i ( client_strobe[i] )
        ,.payload_i( tag_payload )
        ,.data_r_o ( cfg_bytes[i] )
        ,.new_r_o  ( cfg_new[i] )
        );
  end

  //////////////////////////////////////////////////
  // controller field decode

  dmc_cfg_decoder
    decoder
      (.clk_i         ( clk_i )
      ,.rst_n_i       ( rst_n_i )
      ,.cfg_bytes_i   ( cfg_bytes )
      ,.new_i         ( cfg_new )
      ,.trefi_o       ( trefi_o )
      ,.tmrd_o        ( tmrd_o )
      ,.trfc_o        ( trfc_o )
      ,.trc_o         ( trc_o )
      ,.trp_o         ( trp_o )
      ,.tras_o        ( tras_o )
      ,.trrd_o        ( trrd_o )
      ,.trcd_o        ( trcd_o )
      ,.twr_o         ( twr_o )
      ,.twtr_o        ( twtr_o )
      ,.trtp_o        ( trtp_o )
      ,.tcas_o        ( tcas_o )
      ,.col_width_o   ( col_width_o )
      ,.row_width_o   ( row_width_o )
      ,.init_cmd_cnt_o( init_cmd_cnt_o )
      ,.bank_width_o  ( bank_width_o )
      ,.dqs_sel_cal_o ( dqs_sel_cal_o )
      ,.bank_pos_o    ( bank_pos_o )
      ,.bypass_o      ( bypass_o )
      ,.sys_reset_o   ( sys_reset_o )
      ,.cfg_update_o  ( cfg_update_o )
      ,.cfg_valid_o   ( cfg_valid_o )
      );

endmodule

//--- verilog/dmc_cfg_decoder.sv
`include "dmc_cfg_macros.svh"

module dmc_cfg_decoder
  (input  logic                                            clk_i
  ,input  logic                                            rst_n_i
  ,input  dmc_cfg_pkg::dmc_cfg_byte_t [`DMC_CFG_BYTES-1:0] cfg_bytes_i
  ,input  logic [`DMC_CFG_BYTES-1:0]                       new_i
  ,output dmc_cfg_pkg::dmc_trefi_t                         trefi_o
  ,output dmc_cfg_pkg::dmc_nibble_t                        tmrd_o
  ,output dmc_cfg_pkg::dmc_nibble_t                        trfc_o
  ,output dmc_cfg_pkg::dmc_nibble_t                        trc_o
  ,output dmc_cfg_pkg::dmc_nibble_t                        trp_o
  ,output dmc_cfg_pkg::dmc_nibble_t                        tras_o
  ,output dmc_cfg_pkg::dmc_nibble_t                        trrd_o
  ,output dmc_cfg_pkg::dmc_nibble_t                        trcd_o
  ,output dmc_cfg_pkg::dmc_nibble_t                        twr_o
  ,output dmc_cfg_pkg::dmc_nibble_t                        twtr_o
  ,output dmc_cfg_pkg::dmc_nibble_t                        trtp_o
  ,output dmc_cfg_pkg::dmc_nibble_t                        tcas_o
  ,output dmc_cfg_pkg::dmc_nibble_t                        col_width_o
  ,output dmc_cfg_pkg::dmc_nibble_t                        row_width_o
  ,output dmc_cfg_pkg::dmc_nibble_t                        init_cmd_cnt_o
  ,output logic [1:0]                                      bank_width_o
  ,output logic [1:0]                                      dqs_sel_cal_o
  ,output logic [5:0]                                      bank_pos_o
  ,output logic                                            bypass_o
  ,output logic                                            sys_reset_o
  ,output logic                                            cfg_update_o
  ,output logic                                            cfg_valid_o
  );

  import dmc_cfg_pkg::*;

  dmc_cfg_u                  cfg_image;
  dmc_cfg_fields_s           fields_r;
  logic                      any_new;
  logic                      cfg_update_r;
  logic [`DMC_CFG_BYTES-1:0] written_r;

  assign cfg_image.bytes = cfg_bytes_i;
  assign any_new         = |new_i;

  //////////////////////////////////////////////////
  // field registers

  // whole image is resampled on any byte write
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      fields_r     <= '0;
      cfg_update_r <= 1'b0;
      written_r    <= '0;
    end
    else
    begin
      cfg_update_r <= any_new;
      written_r    <= written_r | new_i;
      if (any_new)
        fields_r <= cfg_image.fields;
    end
  end

  //////////////////////////////////////////////////
  // outputs

  assign trefi_o        = fields_r.trefi;
  assign tmrd_o         = fields_r.tmrd;
  assign trfc_o         = fields_r.trfc;
  assign trc_o          = fields_r.trc;
  assign trp_o          = fields_r.trp;
  assign tras_o         = fields_r.tras;
  assign trrd_o         = fields_r.trrd;
  assign trcd_o         = fields_r.trcd;
  assign twr_o          = fields_r.twr;
  assign twtr_o         = fields_r.twtr;
  assign trtp_o         = fields_r.trtp;
  assign tcas_o         = fields_r.tcas;
  assign col_width_o    = fields_r.col_width;
  assign row_width_o    = fields_r.row_width;
  assign bank_width_o   = fields_r.bank_width;
  assign bank_pos_o     = fields_r.bank_pos;
  assign dqs_sel_cal_o  = fields_r.dqs_sel_cal;
  assign init_cmd_cnt_o = fields_r.init_cmd_cnt;
  assign bypass_o       = fields_r.bypass;
  assign sys_reset_o    = fields_r.sys_reset;

  assign cfg_update_o = cfg_update_r;
  // rises with the update of the last missing byte
  assign cfg_valid_o  = &written_r;

  cfg_valid_sticky_a : assert property
    (@(posedge clk_i) disable iff (!rst_n_i)
      cfg_valid_o |=> cfg_valid_o);

endmodule

//--- verilog/tag_client.sv
`include "dmc_cfg_macros.svh"

module tag_client
  (input  logic                       clk_i
  ,input  logic                       rst_n_i
  ,input  logic                       strobe_i
  ,input  dmc_cfg_pkg::dmc_cfg_byte_t payload_i
  ,output dmc_cfg_pkg::dmc_cfg_byte_t data_r_o
  ,output logic                       new_r_o
  );

  import dmc_cfg_pkg::*;

  dmc_cfg_byte_t data_r;
  logic          new_r;

  // byte holds until the next write to this client
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      data_r <= '0;
      new_r  <= 1'b0;
    end
    else
    begin
      new_r <= strobe_i;
      if (strobe_i)
        data_r <= payload_i;
    end
  end

  assign data_r_o = data_r;
  assign new_r_o  = new_r;

  // master must present a clean byte with the strobe
  payload_known_a : assert property
    (@(posedge clk_i) disable iff (!rst_n_i)
      strobe_i |-> !$isunknown(payload_i));

endmodule

//--- verilog/tag_master.sv
`include "dmc_cfg_macros.svh"

module tag_master
  (input  logic                       clk_i
  ,input  logic                       rst_n_i
  ,input  logic                       tag_data_i
  ,input  logic                       tag_en_i
  ,output logic [`DMC_CFG_BYTES-1:0]  client_strobe_o
  ,output dmc_cfg_pkg::dmc_cfg_byte_t payload_o
  );

  import dmc_cfg_pkg::*;

  // bits that follow the start bit
  localparam int shift_bits_lp = `TAG_PACKET_BITS - 1;
  localparam int cnt_width_lp  = $clog2(shift_bits_lp);

  logic                      tag_bit;
  logic                      busy_r;
  logic [cnt_width_lp-1:0]   bit_cnt_r;
  logic [shift_bits_lp-2:0]  shift_r;
  logic                      last_bit;
  logic [`TAG_ID_WIDTH-1:0]  packet_id;
  dmc_cfg_byte_t             packet_payload;
  logic [`DMC_CFG_BYTES-1:0] strobe_n;
  logic [`DMC_CFG_BYTES-1:0] client_strobe_r;
  dmc_cfg_byte_t             payload_r;

  // pin reads as zero while disabled
  assign tag_bit = tag_en_i & tag_data_i;

  assign last_bit = busy_r & (bit_cnt_r == cnt_width_lp'(shift_bits_lp - 1));

  // the last payload bit is still on the pin
  assign packet_id      = shift_r[shift_bits_lp-2 -: `TAG_ID_WIDTH];
  assign packet_payload = {shift_r[`TAG_PAYLOAD_WIDTH-2:0], tag_bit};

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      busy_r    <= 1'b0;
      bit_cnt_r <= '0;
    end
    else if (!busy_r)
    begin
      // zeros between packets are dropped
      if (tag_bit)
      begin
        busy_r    <= 1'b1;
        bit_cnt_r <= '0;
      end
    end
    else
    begin
      bit_cnt_r <= bit_cnt_r + 1'b1;
      if (last_bit)
        busy_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (busy_r)
      shift_r <= {shift_r[shift_bits_lp-3:0], tag_bit};
  end

  // ids past the last client select nothing
  always_comb
  begin
    strobe_n = '0;
    for (int i = 0; i < `DMC_CFG_BYTES; i++)
      strobe_n[i] = last_bit && (packet_id == `TAG_ID_WIDTH'(i));
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      client_strobe_r <= '0;
    else
      client_strobe_r <= strobe_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (last_bit)
      payload_r <= packet_payload;
  end

  assign client_strobe_o = client_strobe_r;
  assign payload_o       = payload_r;

  // packets are longer than one cycle
  strobe_single_cycle_a : assert property
    (@(posedge clk_i) disable iff (!rst_n_i)
      (|client_strobe_o) |=> !(|client_strobe_o));

endmodule

//--- verilog/dmc_cfg_pkg.sv
`include "dmc_cfg_macros.svh"

package dmc_cfg_pkg;

  typedef logic [`TAG_PAYLOAD_WIDTH-1:0] dmc_cfg_byte_t;
  typedef logic [3:0]                    dmc_nibble_t;
  typedef logic [15:0]                   dmc_trefi_t;

  // field layout of the image, byte 11 at the top
  typedef struct packed {
    logic [6:0]  unused_b11;
    logic        sys_reset;
    logic        unused_b10;
    logic        bypass;
    dmc_nibble_t init_cmd_cnt;
    logic [1:0]  dqs_sel_cal;
    logic [5:0]  bank_pos;
    logic [1:0]  bank_width;
    dmc_nibble_t row_width;
    dmc_nibble_t col_width;
    dmc_nibble_t unused_b7;
    dmc_nibble_t tcas;
    dmc_nibble_t trtp;
    dmc_nibble_t twtr;
    dmc_nibble_t twr;
    dmc_nibble_t trcd;
    dmc_nibble_t trrd;
    dmc_nibble_t tras;
    dmc_nibble_t trp;
    dmc_nibble_t trc;
    dmc_nibble_t trfc;
    dmc_nibble_t tmrd;
    // bytes 1 and 0
    dmc_trefi_t  trefi;
  } dmc_cfg_fields_s;

  // same 96 bits, as raw tag bytes or as controller fields
  typedef union packed {
    dmc_cfg_byte_t [`DMC_CFG_BYTES-1:0] bytes;
    dmc_cfg_fields_s                    fields;
  } dmc_cfg_u;

endpackage

//--- verilog/dmc_cfg_macros.svh
`ifndef DMC_CFG_MACROS_SVH
`define DMC_CFG_MACROS_SVH

// one tag client per configuration byte
`define DMC_CFG_BYTES 12

`define TAG_ID_WIDTH 4
`define TAG_PAYLOAD_WIDTH 8

// start bit, then id and payload MSB first
`define TAG_PACKET_BITS (1 + `TAG_ID_WIDTH + `TAG_PAYLOAD_WIDTH)

`endif
